/* project.f */
+incdir+source
source/thread_pkg.sv
source/thread_cmd_decode.sv
source/thread_csr.sv
source/thread_sched.sv
source/thread_ctrl.sv
tb/thread_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the thread controller testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=thread_ctrl_tb

verilator --binary --timing --assert -f project.f --top-module "$TOP" -o "V$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi

/* source/thread_cmd_decode.sv */
//**************************************************************************
// Command decoder: prioritises the strobes into one opcode and picks the
// slot for a new thread
//**************************************************************************

`include "thread_ctrl_defines.svh"

module thread_cmd_decode (
    input  logic                  init_trd,
    input  logic                  kill,
    input  logic                  slp,
    input  logic                  wake,
    input  thread_pkg::trd_idx_t  obj_trd,
    input  thread_pkg::trd_mask_t valid_trd,
    output thread_pkg::trd_op_e   op,
    output thread_pkg::trd_idx_t  tgt,
    output logic                  trd_full,
    output logic                  error
);

    thread_pkg::trd_idx_t free_slot;
    logic                 slot_found;

    // Lowest free slot; thread 0 is never handed out to a create
    always_comb begin
        free_slot  = '0;
        slot_found = 1'b0;
        for (int i = `THREAD_NUM - 1; i >= 1; i--) begin
            if (!valid_trd[i]) begin
                free_slot  = thread_pkg::trd_idx_t'(i);
                slot_found = 1'b1;
            end
        end
    end

    assign trd_full = !slot_found;
    assign error    = init_trd && trd_full;     // Create with nowhere to go

    // Fixed priority: create, kill, sleep, wake
    always_comb begin
        op  = thread_pkg::OP_NONE;
        tgt = obj_trd;
        if (init_trd) begin
            if (!trd_full) begin
                op  = thread_pkg::OP_CREATE;
                tgt = free_slot;
            end
        end else if (kill) begin
            op = thread_pkg::OP_KILL;
        end else if (slp) begin
            op = thread_pkg::OP_SLEEP;
        end else if (wake) begin
            op = thread_pkg::OP_WAKE;
        end

        // A create only lands on a free slot above thread 0, so never when full
        a_create_slot_free: assert (!(op == thread_pkg::OP_CREATE &&
                                      (valid_trd[tgt] || tgt == '0)))
            else $error("create aimed at a thread slot that is in use");
    end

endmodule

/* source/thread_csr.sv */
//**************************************************************************
// Status register of one hardware thread: state, parent, PC and the
// ownership check on kill, sleep and wake; one instance per thread
//**************************************************************************

`include "thread_ctrl_defines.svh"

module thread_csr #(
    parameter int TRD_ID = 0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  thread_pkg::trd_op_e  op,
    input  thread_pkg::trd_idx_t tgt,
    input  thread_pkg::trd_idx_t act_trd,
    input  thread_pkg::pc_t      init_pc,
    input  logic                 pc_wr,
    input  thread_pkg::pc_t      nxt_pc,
    output thread_pkg::pc_t      cur_pc,
    output logic                 valid,
    output logic                 running,
    output logic                 error
);

    localparam thread_pkg::trd_idx_t SELF = thread_pkg::trd_idx_t'(TRD_ID);

    // Thread 0 comes out of reset already running
    localparam thread_pkg::trd_state_e RST_STATE =
        (TRD_ID == 0) ? thread_pkg::RUNNING : thread_pkg::FREE;

    thread_pkg::trd_state_e state;
    thread_pkg::trd_state_e state_nxt;
    thread_pkg::trd_idx_t   parent;
    thread_pkg::pc_t        pc_q;

    logic hit;
    logic create;
    logic ctl_cmd;
    logic owner_ok;

    assign hit      = (tgt == SELF);
    assign create   = hit && (op == thread_pkg::OP_CREATE);
    assign ctl_cmd  = hit && (op inside {thread_pkg::OP_KILL,
                                         thread_pkg::OP_SLEEP,
                                         thread_pkg::OP_WAKE});

    // Only the thread itself or the one that created it may control it
    assign owner_ok = valid && ((act_trd == SELF) || (act_trd == parent));

    assign valid    = (state != thread_pkg::FREE);
    assign running  = (state == thread_pkg::RUNNING);
    assign error    = ctl_cmd && !owner_ok;     // Rejected command, no state change
    assign cur_pc   = pc_q;

    always_comb begin
        state_nxt = state;
        if (hit) begin
            case (op)
                thread_pkg::OP_CREATE: state_nxt = thread_pkg::RUNNING;
                thread_pkg::OP_KILL: begin
                    if (owner_ok) state_nxt = thread_pkg::FREE;
                end
                thread_pkg::OP_SLEEP: begin
                    if (owner_ok) state_nxt = thread_pkg::SLEEPING;
                end
                thread_pkg::OP_WAKE: begin
                    if (owner_ok) state_nxt = thread_pkg::RUNNING;
                end
                default: state_nxt = state;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RST_STATE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            parent <= SELF;                     // Thread 0 owns itself
            pc_q   <= `RESET_PC;
        end else if (create) begin
            parent <= act_trd;
            pc_q   <= init_pc;                  // Create beats a PC write
        end else if (pc_wr) begin
            pc_q   <= nxt_pc;
        end
    end

    // A create must not overwrite the parent and PC of a live thread
    a_create_free: assert property (@(posedge clk) disable iff (!rst_n)
        create |-> !valid)
        else $error("create aimed at thread %0d while it is in use", TRD_ID);

endmodule

/* source/thread_ctrl.sv */
//**************************************************************************
// Thread controller top for the fetch stage; decoder, one status register
// per thread and the round-robin scheduler
//**************************************************************************

`include "thread_ctrl_defines.svh"

module thread_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                init_trd,
    input  logic                                kill,
    input  logic                                slp,
    input  logic                                wake,
    input  thread_pkg::trd_idx_t                act_trd,    // Thread issuing the command
    input  thread_pkg::trd_idx_t                obj_trd,    // Thread being acted on
    input  thread_pkg::pc_t                     init_pc,
    input  logic                                stall,
    input  logic                                atomic,
    input  thread_pkg::trd_mask_t               pc_wr,
    input  thread_pkg::pc_t [`THREAD_NUM-1:0]   nxt_pc,
    output thread_pkg::trd_idx_t                cur_trd,
    output thread_pkg::trd_idx_t                nxt_trd,
    output thread_pkg::trd_idx_t                new_trd,
    output thread_pkg::trd_mask_t               valid_trd,
    output thread_pkg::trd_mask_t               run_trd,
    output logic                                trd_full,
    output logic                                invalid_op,
    output logic                                error,
    output thread_pkg::pc_t                     cur_pc
);

    thread_pkg::trd_op_e                op;
    thread_pkg::trd_idx_t               tgt;
    thread_pkg::pc_t [`THREAD_NUM-1:0]  csr_pc;
    thread_pkg::trd_mask_t              csr_error;

    thread_cmd_decode u_decode (
        .init_trd   (init_trd),
        .kill       (kill),
        .slp        (slp),
        .wake       (wake),
        .obj_trd    (obj_trd),
        .valid_trd  (valid_trd),
        .op         (op),
        .tgt        (tgt),
        .trd_full   (trd_full),
        .error      (error)
    );

    for (genvar i = 0; i < `THREAD_NUM; i++) begin : g_csr
        thread_csr #(
            .TRD_ID (i)
        ) u_csr (
            .clk        (clk),
            .rst_n      (rst_n),
            .op         (op),
            .tgt        (tgt),
            .act_trd    (act_trd),
            .init_pc    (init_pc),
            .pc_wr      (pc_wr[i]),
            .nxt_pc     (nxt_pc[i]),
            .cur_pc     (csr_pc[i]),
            .valid      (valid_trd[i]),
            .running    (run_trd[i]),
            .error      (csr_error[i])
        );
    end

    thread_sched u_sched (
        .clk        (clk),
        .rst_n      (rst_n),
        .run_trd    (run_trd),
        .stall      (stall),
        .atomic     (atomic),
        .pc_array   (csr_pc),
        .csr_error  (csr_error),
        .cur_trd    (cur_trd),
        .nxt_trd    (nxt_trd),
        .cur_pc     (cur_pc),
        .invalid_op (invalid_op)
    );

    // Slot taken by the most recent accepted create
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            new_trd <= '0;
        end else if (op == thread_pkg::OP_CREATE) begin
            new_trd <= tgt;
        end
    end

endmodule

/* source/thread_ctrl_defines.svh */
//**************************************************************************
// Sizing constants for the thread controller, shared by the RTL and the
// testbench through `include
//**************************************************************************

`ifndef THREAD_CTRL_DEFINES_SVH
`define THREAD_CTRL_DEFINES_SVH

// Number of hardware threads, kept a power of two so index math wraps
`define THREAD_NUM      8

// Bits needed to name one thread
`define THREAD_IDX_W    3

// Program counter width
`define PC_W            32

// Start address of thread 0 after reset
`define RESET_PC        32'h0000_0000

`endif

/* source/thread_pkg.sv */
//**************************************************************************
// Types shared by the thread controller blocks and its testbench
//**************************************************************************

`include "thread_ctrl_defines.svh"

package thread_pkg;

    typedef enum logic [1:0] {
        FREE,                                   // Slot unused
        RUNNING,                                // Eligible for the pointer
        SLEEPING                                // Allocated but parked
    } trd_state_e;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_CREATE,
        OP_KILL,
        OP_SLEEP,
        OP_WAKE
    } trd_op_e;

    typedef logic [`THREAD_IDX_W-1:0] trd_idx_t;
    typedef logic [`THREAD_NUM-1:0]   trd_mask_t;   // One bit per thread
    typedef logic [`PC_W-1:0]         pc_t;

endpackage

/* source/thread_sched.sv */
//**************************************************************************
// Round-robin thread pointer for fetch; picks the current PC and merges
// the per-thread command errors
//**************************************************************************

`include "thread_ctrl_defines.svh"

module thread_sched (
    input  logic                                clk,
    input  logic                                rst_n,
    input  thread_pkg::trd_mask_t               run_trd,
    input  logic                                stall,
    input  logic                                atomic,
    input  thread_pkg::pc_t [`THREAD_NUM-1:0]   pc_array,
    input  thread_pkg::trd_mask_t               csr_error,
    output thread_pkg::trd_idx_t                cur_trd,
    output thread_pkg::trd_idx_t                nxt_trd,
    output thread_pkg::pc_t                     cur_pc,
    output logic                                invalid_op
);

    thread_pkg::trd_idx_t cand;
    logic                 found;

    // First running thread above cur_trd, wrapping through the index width
    always_comb begin
        nxt_trd = cur_trd;
        found   = 1'b0;
        cand    = cur_trd;
        for (int k = 1; k < `THREAD_NUM; k++) begin
            cand = cur_trd + thread_pkg::trd_idx_t'(k);
            if (!found && run_trd[cand]) begin
                nxt_trd = cand;
                found   = 1'b1;
            end
        end
        if (stall || atomic) begin
            nxt_trd = cur_trd;                  // Hold the pointer
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_trd <= '0;
        end else begin
            cur_trd <= nxt_trd;
        end
    end

    assign cur_pc     = pc_array[cur_trd];
    assign invalid_op = |csr_error;             // Any thread rejected its command

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(cur_trd))
        else $error("thread pointer moved across a stall");

endmodule

/* tb/thread_ctrl_tb.sv */
//**************************************************************************
// Table-driven testbench for the thread controller, with a scheduler model
// and random PC writes; top module of the simulation
//**************************************************************************

`include "thread_ctrl_defines.svh"

module thread_ctrl_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [1:0] H_NONE  = 2'b00;
    localparam logic [1:0] H_STALL = 2'b10;
    localparam logic [1:0] H_ATOM  = 2'b01;
    localparam logic [1:0] H_BOTH  = 2'b11;

    typedef struct packed {
        thread_pkg::trd_op_e   op;
        thread_pkg::trd_idx_t  act;
        thread_pkg::trd_idx_t  obj;
        thread_pkg::pc_t       ipc;
        logic [1:0]            hold;                // {stall, atomic}
        thread_pkg::trd_mask_t e_valid;
        thread_pkg::trd_mask_t e_run;
        thread_pkg::trd_idx_t  e_new;
        logic                  e_full;
        logic                  e_inv;
        logic                  e_err;
    } row_t;

    logic                               clk;
    logic                               rst_n;
    logic                               init_trd;
    logic                               kill;
    logic                               slp;
    logic                               wake;
    thread_pkg::trd_idx_t               act_trd;
    thread_pkg::trd_idx_t               obj_trd;
    thread_pkg::pc_t                    init_pc;
    logic                               stall;
    logic                               atomic;
    thread_pkg::trd_mask_t              pc_wr;
    thread_pkg::pc_t [`THREAD_NUM-1:0]  nxt_pc;
    thread_pkg::trd_idx_t               cur_trd;
    thread_pkg::trd_idx_t               nxt_trd;
    thread_pkg::trd_idx_t               new_trd;
    thread_pkg::trd_mask_t              valid_trd;
    thread_pkg::trd_mask_t              run_trd;
    logic                               trd_full;
    logic                               invalid_op;
    logic                               error;
    thread_pkg::pc_t                    cur_pc;

    row_t                  rows[$];
    string                 row_names[$];
    row_t                  r;
    thread_pkg::pc_t       model_pc[`THREAD_NUM];
    thread_pkg::trd_idx_t  model_cur;
    thread_pkg::trd_idx_t  exp_nxt;
    thread_pkg::trd_mask_t model_run;
    thread_pkg::trd_idx_t  wr_idx;
    thread_pkg::pc_t       rnd_pc;
    logic [31:0]           rnd;
    logic [31:0]           seed = 32'ha5ed6e8b;
    int                    checks = 0;
    int                    errors = 0;
    int                    cycles = 0;
    int                    cycle_limit = 50;

    thread_ctrl u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .init_trd   (init_trd),
        .kill       (kill),
        .slp        (slp),
        .wake       (wake),
        .act_trd    (act_trd),
        .obj_trd    (obj_trd),
        .init_pc    (init_pc),
        .stall      (stall),
        .atomic     (atomic),
        .pc_wr      (pc_wr),
        .nxt_pc     (nxt_pc),
        .cur_trd    (cur_trd),
        .nxt_trd    (nxt_trd),
        .new_trd    (new_trd),
        .valid_trd  (valid_trd),
        .run_trd    (run_trd),
        .trd_full   (trd_full),
        .invalid_op (invalid_op),
        .error      (error),
        .cur_pc     (cur_pc)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // 32-bit LCG with the Numerical Recipes constants
    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Next pointer by the round-robin rule over the run mask
    function automatic thread_pkg::trd_idx_t predict_next(input thread_pkg::trd_idx_t cur,
                                                          input thread_pkg::trd_mask_t run,
                                                          input logic hold);
        thread_pkg::trd_idx_t idx;
        if (hold) return cur;
        for (int k = 1; k < `THREAD_NUM; k++) begin
            idx = thread_pkg::trd_idx_t'((int'(cur) + k) % `THREAD_NUM);
            if (run[idx]) return idx;
        end
        return cur;
    endfunction

    task automatic add_row(input string name, input thread_pkg::trd_op_e op,
                           input thread_pkg::trd_idx_t act, input thread_pkg::trd_idx_t obj,
                           input thread_pkg::pc_t ipc, input logic [1:0] hold,
                           input thread_pkg::trd_mask_t e_valid,
                           input thread_pkg::trd_mask_t e_run,
                           input thread_pkg::trd_idx_t e_new,
                           input logic e_full, input logic e_inv, input logic e_err);
        row_t row;
        row = '{op, act, obj, ipc, hold, e_valid, e_run, e_new, e_full, e_inv, e_err};
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic check_mask(input string name, input string what,
                              input thread_pkg::trd_mask_t exp, input thread_pkg::trd_mask_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: %s expected %h, got %h", name, what, exp, got);
        end
    endtask

    task automatic check_idx(input string name, input string what,
                             input thread_pkg::trd_idx_t exp, input thread_pkg::trd_idx_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: %s expected %0d, got %0d", name, what, exp, got);
        end
    endtask

    task automatic check_pc(input string name, input string what,
                            input thread_pkg::pc_t exp, input thread_pkg::pc_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: %s expected %h, got %h", name, what, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: %s expected %b, got %b", name, what, exp, got);
        end
    endtask

    task automatic apply_row(input row_t row, input thread_pkg::trd_idx_t widx,
                             input thread_pkg::pc_t wval);
        init_trd = (row.op == thread_pkg::OP_CREATE);
        kill     = (row.op == thread_pkg::OP_KILL);
        slp      = (row.op == thread_pkg::OP_SLEEP);
        wake     = (row.op == thread_pkg::OP_WAKE);
        act_trd  = row.act;
        obj_trd  = row.obj;
        init_pc  = row.ipc;
        stall    = row.hold[1];
        atomic   = row.hold[0];
        pc_wr    = '0;
        pc_wr[widx] = 1'b1;                         // One random PC write per row
        nxt_pc   = '0;
        nxt_pc[widx] = wval;
    endtask

    task automatic build_table();
        add_row("idle_after_reset", thread_pkg::OP_NONE, 3'd0, 3'd0, 32'h0, H_NONE,
                8'h01, 8'h01, 3'd0, 1'b0, 1'b0, 1'b0);
        for (int t = 1; t < `THREAD_NUM; t++) begin  // Fill slots 1 to 7 in order
            add_row($sformatf("create_t%0d", t), thread_pkg::OP_CREATE, 3'd0, 3'd0,
                    32'h1000 + 32'(t) * 32'h100, H_NONE, 8'((2 << t) - 1), 8'((2 << t) - 1),
                    3'(t), 1'b0, 1'b0, 1'b0);
        end
        add_row("create_when_full", thread_pkg::OP_CREATE, 3'd0, 3'd0, 32'h1800, H_NONE,
                8'hff, 8'hff, 3'd7, 1'b1, 1'b0, 1'b1);
        add_row("sleep_t3", thread_pkg::OP_SLEEP, 3'd0, 3'd3, 32'h0, H_NONE,
                8'hff, 8'hf7, 3'd7, 1'b1, 1'b0, 1'b0);
        add_row("wake_t3", thread_pkg::OP_WAKE, 3'd0, 3'd3, 32'h0, H_NONE,
                8'hff, 8'hff, 3'd7, 1'b1, 1'b0, 1'b0);
        add_row("kill_t5", thread_pkg::OP_KILL, 3'd0, 3'd5, 32'h0, H_NONE,
                8'hdf, 8'hdf, 3'd7, 1'b1, 1'b0, 1'b0);
        add_row("create_reuse_t5", thread_pkg::OP_CREATE, 3'd0, 3'd0, 32'h1900, H_NONE,
                8'hff, 8'hff, 3'd5, 1'b0, 1'b0, 1'b0);
        add_row("kill_t6", thread_pkg::OP_KILL, 3'd0, 3'd6, 32'h0, H_NONE,
                8'hbf, 8'hbf, 3'd5, 1'b1, 1'b0, 1'b0);
        add_row("create_t6_from_t2", thread_pkg::OP_CREATE, 3'd2, 3'd0, 32'h1a00, H_NONE,
                8'hff, 8'hff, 3'd6, 1'b0, 1'b0, 1'b0);
        add_row("kill_t6_not_parent", thread_pkg::OP_KILL, 3'd3, 3'd6, 32'h0, H_NONE,
                8'hff, 8'hff, 3'd6, 1'b1, 1'b1, 1'b0);
        add_row("sleep_t6_not_parent", thread_pkg::OP_SLEEP, 3'd1, 3'd6, 32'h0, H_NONE,
                8'hff, 8'hff, 3'd6, 1'b1, 1'b1, 1'b0);
        add_row("sleep_t6_by_parent", thread_pkg::OP_SLEEP, 3'd2, 3'd6, 32'h0, H_NONE,
                8'hff, 8'hbf, 3'd6, 1'b1, 1'b0, 1'b0);
        add_row("wake_t6_by_self", thread_pkg::OP_WAKE, 3'd6, 3'd6, 32'h0, H_NONE,
                8'hff, 8'hff, 3'd6, 1'b1, 1'b0, 1'b0);
        add_row("kill_t4", thread_pkg::OP_KILL, 3'd0, 3'd4, 32'h0, H_NONE,
                8'hef, 8'hef, 3'd6, 1'b1, 1'b0, 1'b0);
        add_row("kill_freed_t4", thread_pkg::OP_KILL, 3'd0, 3'd4, 32'h0, H_NONE,
                8'hef, 8'hef, 3'd6, 1'b0, 1'b1, 1'b0);
        add_row("sleep_freed_t4", thread_pkg::OP_SLEEP, 3'd4, 3'd4, 32'h0, H_NONE,
                8'hef, 8'hef, 3'd6, 1'b0, 1'b1, 1'b0);
        add_row("stall_hold", thread_pkg::OP_NONE, 3'd0, 3'd0, 32'h0, H_STALL,
                8'hef, 8'hef, 3'd6, 1'b0, 1'b0, 1'b0);
        add_row("atomic_hold", thread_pkg::OP_NONE, 3'd0, 3'd0, 32'h0, H_ATOM,
                8'hef, 8'hef, 3'd6, 1'b0, 1'b0, 1'b0);
        add_row("both_hold", thread_pkg::OP_NONE, 3'd0, 3'd0, 32'h0, H_BOTH,
                8'hef, 8'hef, 3'd6, 1'b0, 1'b0, 1'b0);
        add_row("sleep_t1", thread_pkg::OP_SLEEP, 3'd0, 3'd1, 32'h0, H_NONE,
                8'hef, 8'hed, 3'd6, 1'b0, 1'b0, 1'b0);
        add_row("sleep_t2", thread_pkg::OP_SLEEP, 3'd0, 3'd2, 32'h0, H_NONE,
                8'hef, 8'he9, 3'd6, 1'b0, 1'b0, 1'b0);
        for (int n = 0; n < 4; n++) begin           // Pointer walks the sparse mask
            add_row($sformatf("rr_walk_%0d", n), thread_pkg::OP_NONE, 3'd0, 3'd0, 32'h0,
                    (n == 2) ? H_STALL : H_NONE, 8'hef, 8'he9, 3'd6, 1'b0, 1'b0, 1'b0);
        end
        add_row("create_reuse_t4", thread_pkg::OP_CREATE, 3'd0, 3'd0, 32'h1b00, H_NONE,
                8'hff, 8'hf9, 3'd4, 1'b0, 1'b0, 1'b0);
        add_row("wake_t1", thread_pkg::OP_WAKE, 3'd0, 3'd1, 32'h0, H_NONE,
                8'hff, 8'hfb, 3'd4, 1'b1, 1'b0, 1'b0);
        add_row("wake_t2_not_parent", thread_pkg::OP_WAKE, 3'd1, 3'd2, 32'h0, H_NONE,
                8'hff, 8'hfb, 3'd4, 1'b1, 1'b1, 1'b0);
        add_row("wake_t2", thread_pkg::OP_WAKE, 3'd0, 3'd2, 32'h0, H_NONE,
                8'hff, 8'hff, 3'd4, 1'b1, 1'b0, 1'b0);
        add_row("rr_idle", thread_pkg::OP_NONE, 3'd0, 3'd0, 32'h0, H_NONE,
                8'hff, 8'hff, 3'd4, 1'b1, 1'b0, 1'b0);
        add_row("rr_atomic", thread_pkg::OP_NONE, 3'd0, 3'd0, 32'h0, H_ATOM,
                8'hff, 8'hff, 3'd4, 1'b1, 1'b0, 1'b0);
    endtask

    initial begin
        rst_n     = 1'b0;
        apply_row('0, 3'd0, 32'h0);
        pc_wr     = '0;
        build_table();
        cycle_limit = rows.size() * 4 + 50;
        for (int t = 0; t < `THREAD_NUM; t++) begin
            model_pc[t] = `RESET_PC;
        end
        model_cur = '0;
        model_run = 8'h01;

        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        check_mask("reset", "valid_trd", 8'h01, valid_trd);
        check_mask("reset", "run_trd", 8'h01, run_trd);
        check_idx("reset", "cur_trd", 3'd0, cur_trd);
        check_idx("reset", "new_trd", 3'd0, new_trd);
        check_pc("reset", "cur_pc", `RESET_PC, cur_pc);
        check_bit("reset", "invalid_op", 1'b0, invalid_op);
        check_bit("reset", "error", 1'b0, error);

        for (int i = 0; i < rows.size(); i++) begin
            r      = rows[i];
            rnd    = next_random();
            wr_idx = rnd[30:28];
            if (r.op == thread_pkg::OP_CREATE) begin
                wr_idx = r.e_new;                   // Write collides with the create slot
            end
            rnd_pc = next_random();
            apply_row(r, wr_idx, rnd_pc);

            // Combinational flags and pointer at mid-cycle before the edge
            @(negedge clk);
            exp_nxt = predict_next(model_cur, model_run, r.hold != H_NONE);
            check_bit(row_names[i], "trd_full", r.e_full, trd_full);
            check_bit(row_names[i], "invalid_op", r.e_inv, invalid_op);
            check_bit(row_names[i], "error", r.e_err, error);
            check_idx(row_names[i], "cur_trd", model_cur, cur_trd);
            check_idx(row_names[i], "nxt_trd", exp_nxt, nxt_trd);
            check_pc(row_names[i], "cur_pc", model_pc[model_cur], cur_pc);

            model_pc[wr_idx] = rnd_pc;
            if (r.op == thread_pkg::OP_CREATE && !r.e_err) begin
                model_pc[r.e_new] = r.ipc;          // Create beats the PC write
            end
            model_cur = exp_nxt;
            model_run = r.e_run;

            // Registered state just after the edge
            @(posedge clk);
            #1;
            check_mask(row_names[i], "valid_trd", r.e_valid, valid_trd);
            check_mask(row_names[i], "run_trd", r.e_run, run_trd);
            check_idx(row_names[i], "new_trd", r.e_new, new_trd);
        end

        apply_row('0, 3'd0, 32'h0);
        pc_wr = '0;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
